/* mem_net_defines.svh */
//========================================
// memory network defines
// widths, port count and sizing
//========================================

`ifndef MEM_NET_DEFINES_SVH
`define MEM_NET_DEFINES_SVH

// memory message fields
`define MEM_OPAQUE_NBITS 8
`define MEM_ADDR_NBITS 32
`define MEM_DATA_NBITS 32
`define MEM_LEN_NBITS 2

// network shape, cores equal banks
`define NET_NUM_PORTS 2
`define NET_SRCDEST_NBITS 1
`define NET_QUEUE_DEPTH 4

// bank sizing
`define BANK_NWORDS 256

// address boundaries for bank selection
`define INST_BANK_SPLIT 32'h0000_4000
`define DATA_BANK_SPLIT 32'h0000_c000

`endif

/* mem_net_pkg.sv */
//========================================
// memory network types
// message type and network message layouts
//========================================

`include "mem_net_defines.svh"

package mem_net_pkg;

  // memory message type
  typedef enum logic [0:0] {
    MEM_MSG_READ  = 1'b0,
    MEM_MSG_WRITE = 1'b1
  } mem_msg_type_t;

  //========================================
  // request network message
  //========================================

  // control part, data word travels beside it
  typedef struct packed {
    logic [`NET_SRCDEST_NBITS-1:0] dest;
    logic [`NET_SRCDEST_NBITS-1:0] src;
    mem_msg_type_t                 msg_type;
    logic [`MEM_OPAQUE_NBITS-1:0]  opaque;
    logic [`MEM_ADDR_NBITS-1:0]    addr;
    logic [`MEM_LEN_NBITS-1:0]     len;
  } net_req_ctrl_t;

  // switch payload for the request network
  typedef struct packed {
    net_req_ctrl_t              ctrl;
    logic [`MEM_DATA_NBITS-1:0] data;
  } net_req_msg_t;

  //========================================
  // response network message
  //========================================

  typedef struct packed {
    logic [`NET_SRCDEST_NBITS-1:0] dest;
    logic [`NET_SRCDEST_NBITS-1:0] src;
    mem_msg_type_t                 msg_type;
    logic [`MEM_OPAQUE_NBITS-1:0]  opaque;
    logic [`MEM_LEN_NBITS-1:0]     len;
  } net_resp_ctrl_t;

  typedef struct packed {
    net_resp_ctrl_t             ctrl;
    logic [`MEM_DATA_NBITS-1:0] data;
  } net_resp_msg_t;

endpackage

/* mem_req_to_net.sv */
//========================================
// memory request to network adapter
// picks the bank, stamps the core id into opaque
//========================================

`include "mem_net_defines.svh"

module mem_req_to_net
  import mem_net_pkg::*;
#(
  // index of the core behind this port
  parameter int unsigned p_net_src = 0
) (
  input  logic                         mode,
  input  mem_msg_type_t                mem_type,
  input  logic [`MEM_OPAQUE_NBITS-1:0] mem_opaque,
  input  logic [`MEM_ADDR_NBITS-1:0]   mem_addr,
  input  logic [`MEM_LEN_NBITS-1:0]    mem_len,
  input  logic [`MEM_DATA_NBITS-1:0]   mem_data,
  output net_req_ctrl_t                net_ctrl,
  output logic [`MEM_DATA_NBITS-1:0]   net_data
);

  localparam int MO = `MEM_OPAQUE_NBITS;
  localparam int NS = `NET_SRCDEST_NBITS;
  localparam logic [NS-1:0] SRC_ID = p_net_src[NS-1:0];

  logic [NS-1:0] net_dest;
  logic [MO-1:0] src_opaque;

  // bank select, mode 0 is instruction and mode 1 is data
  always_comb begin
    if (mode) begin
      net_dest = (mem_addr < `DATA_BANK_SPLIT) ? NS'(0) : NS'(1);
    end else begin
      net_dest = (mem_addr < `INST_BANK_SPLIT) ? NS'(0) : NS'(1);
    end
  end

  // top opaque bits now name the issuing core
  assign src_opaque = {SRC_ID, mem_opaque[MO-NS-1:0]};

  assign net_ctrl = '{
    dest:     net_dest,
    src:      SRC_ID,
    msg_type: mem_type,
    opaque:   src_opaque,
    addr:     mem_addr,
    len:      mem_len
  };

  // data word is carried separately from the control part
  assign net_data = mem_data;

endmodule

/* mem_resp_to_net.sv */
//========================================
// memory response to network adapter
// sends the response back to the core in opaque
//========================================

`include "mem_net_defines.svh"

module mem_resp_to_net
  import mem_net_pkg::*;
#(
  // index of the bank driving this adapter
  parameter int unsigned p_net_src = 0
) (
  input  mem_msg_type_t                mem_type,
  input  logic [`MEM_OPAQUE_NBITS-1:0] mem_opaque,
  input  logic [`MEM_LEN_NBITS-1:0]    mem_len,
  input  logic [`MEM_DATA_NBITS-1:0]   mem_data,
  output net_resp_ctrl_t               net_ctrl,
  output logic [`MEM_DATA_NBITS-1:0]   net_data
);

  localparam int MO = `MEM_OPAQUE_NBITS;
  localparam int NS = `NET_SRCDEST_NBITS;
  localparam logic [NS-1:0] SRC_ID = p_net_src[NS-1:0];

  logic [NS-1:0] net_dest;

  // request adapter left the core id in the top opaque bits
  assign net_dest = mem_opaque[MO-1 -: NS];

  // opaque returns unchanged so the core sees its own tag
  assign net_ctrl = '{
    dest:     net_dest,
    src:      SRC_ID,
    msg_type: mem_type,
    opaque:   mem_opaque,
    len:      mem_len
  };

  assign net_data = mem_data;

endmodule

/* net_switch.sv */
//========================================
// registered 2x2 switch
// input queues, round-robin per output
//========================================

`include "mem_net_defines.svh"

module net_switch #(
  parameter type p_msg_t = logic [7:0]
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_val  [`NET_NUM_PORTS],
  input  logic [`NET_SRCDEST_NBITS-1:0] in_dest [`NET_NUM_PORTS],
  input  p_msg_t                        in_msg  [`NET_NUM_PORTS],
  output logic                          out_val [`NET_NUM_PORTS],
  output p_msg_t                        out_msg [`NET_NUM_PORTS]
);

  localparam int NP = `NET_NUM_PORTS;
  localparam int QD = `NET_QUEUE_DEPTH;
  localparam int PW = $clog2(QD);
  localparam int IW = `NET_SRCDEST_NBITS;

  // queue storage, pointers wrap on a power-of-two depth
  p_msg_t        q_msg    [NP][QD];
  logic [IW-1:0] q_dest   [NP][QD];
  logic [PW-1:0] q_rd_ptr [NP];
  logic [PW-1:0] q_wr_ptr [NP];
  logic [PW:0]   q_count  [NP];

  logic          enq     [NP];
  logic          deq     [NP];
  logic [IW-1:0] rr_ptr  [NP];
  logic          gnt_val [NP];
  logic [IW-1:0] gnt_idx [NP];

  //========================================
  // arbitration
  //========================================

  always_comb begin
    int cand;
    for (int i = 0; i < NP; i++) begin
      // a full queue drops the new message
      enq[i] = in_val[i] && (q_count[i] != QD);
      deq[i] = 1'b0;
    end
    for (int o = 0; o < NP; o++) begin
      gnt_val[o] = 1'b0;
      gnt_idx[o] = '0;
      // walk from lowest priority up so the rr_ptr candidate wins last
      for (int k = NP - 1; k >= 0; k--) begin
        cand = (int'(rr_ptr[o]) + k) % NP;
        if (q_count[cand] != 0 && int'(q_dest[cand][q_rd_ptr[cand]]) == o) begin
          gnt_val[o] = 1'b1;
          gnt_idx[o] = cand[IW-1:0];
        end
      end
      if (gnt_val[o]) begin
        deq[gnt_idx[o]] = 1'b1;
      end
    end
  end

  //========================================
  // queues and output stage
  //========================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NP; i++) begin
        q_rd_ptr[i] <= '0;
        q_wr_ptr[i] <= '0;
        q_count[i]  <= '0;
        rr_ptr[i]   <= '0;
        out_val[i]  <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NP; i++) begin
        if (enq[i]) q_wr_ptr[i] <= q_wr_ptr[i] + 1'b1;
        if (deq[i]) q_rd_ptr[i] <= q_rd_ptr[i] + 1'b1;
        if (enq[i] && !deq[i]) begin
          q_count[i] <= q_count[i] + 1'b1;
        end else if (!enq[i] && deq[i]) begin
          q_count[i] <= q_count[i] - 1'b1;
        end
        // here i names an output
        out_val[i] <= gnt_val[i];
        if (gnt_val[i]) rr_ptr[i] <= gnt_idx[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NP; i++) begin
      if (enq[i]) begin
        q_msg[i][q_wr_ptr[i]]  <= in_msg[i];
        q_dest[i][q_wr_ptr[i]] <= in_dest[i];
      end
      if (gnt_val[i]) out_msg[i] <= q_msg[gnt_idx[i]][q_rd_ptr[gnt_idx[i]]];
    end
  end

endmodule

/* mem_bank.sv */
//========================================
// memory bank
// word-addressed storage, answers one cycle later
//========================================

`include "mem_net_defines.svh"

module mem_bank
  import mem_net_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_val,
  input  mem_msg_type_t                req_type,
  input  logic [`MEM_OPAQUE_NBITS-1:0] req_opaque,
  input  logic [`MEM_ADDR_NBITS-1:0]   req_addr,
  input  logic [`MEM_LEN_NBITS-1:0]    req_len,
  input  logic [`MEM_DATA_NBITS-1:0]   req_data,
  output logic                         resp_val,
  output mem_msg_type_t                resp_type,
  output logic [`MEM_OPAQUE_NBITS-1:0] resp_opaque,
  output logic [`MEM_LEN_NBITS-1:0]    resp_len,
  output logic [`MEM_DATA_NBITS-1:0]   resp_data
);

  localparam int NW    = `BANK_NWORDS;
  localparam int IDX_W = $clog2(NW);

  logic [`MEM_DATA_NBITS-1:0] mem [NW];
  // per-word written flag so untouched words read as zero
  logic [NW-1:0]              word_vld;
  logic [IDX_W-1:0]           word_idx;
  logic                       is_write;

  // word index sits just above the byte offset
  assign word_idx = req_addr[2 +: IDX_W];
  assign is_write = req_val && (req_type == MEM_MSG_WRITE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_val <= 1'b0;
      word_vld <= '0;
    end else begin
      resp_val <= req_val;
      if (is_write) word_vld[word_idx] <= 1'b1;
    end
  end

  // storage and response payload
  always_ff @(posedge clk) begin
    if (is_write) mem[word_idx] <= req_data;
    if (req_val) begin
      resp_type   <= req_type;
      resp_opaque <= req_opaque;
      resp_len    <= req_len;
      if (is_write || !word_vld[word_idx]) begin
        resp_data <= '0;
      end else begin
        resp_data <= mem[word_idx];
      end
    end
  end

endmodule

/* mem_net_top.sv */
//========================================
// two-core two-bank memory network
// request switch to banks, response switch back
//========================================

`include "mem_net_defines.svh"

module mem_net_top
  import mem_net_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_val     [`NET_NUM_PORTS],
  input  logic                         req_mode    [`NET_NUM_PORTS],
  input  mem_msg_type_t                req_type    [`NET_NUM_PORTS],
  input  logic [`MEM_OPAQUE_NBITS-1:0] req_opaque  [`NET_NUM_PORTS],
  input  logic [`MEM_ADDR_NBITS-1:0]   req_addr    [`NET_NUM_PORTS],
  input  logic [`MEM_LEN_NBITS-1:0]    req_len     [`NET_NUM_PORTS],
  input  logic [`MEM_DATA_NBITS-1:0]   req_data    [`NET_NUM_PORTS],
  output logic                         resp_val    [`NET_NUM_PORTS],
  output mem_msg_type_t                resp_type   [`NET_NUM_PORTS],
  output logic [`MEM_OPAQUE_NBITS-1:0] resp_opaque [`NET_NUM_PORTS],
  output logic [`MEM_LEN_NBITS-1:0]    resp_len    [`NET_NUM_PORTS],
  output logic [`MEM_DATA_NBITS-1:0]   resp_data   [`NET_NUM_PORTS]
);

  localparam int NP = `NET_NUM_PORTS;
  localparam int NS = `NET_SRCDEST_NBITS;
  localparam int MD = `MEM_DATA_NBITS;

  // request path
  net_req_ctrl_t req_ctrl     [NP];
  logic [MD-1:0] req_net_data [NP];
  logic [NS-1:0] req_dest     [NP];
  net_req_msg_t  req_in_msg   [NP];
  net_req_msg_t  req_out_msg  [NP];
  logic          req_out_val  [NP];

  // bank responses
  logic                         bank_val    [NP];
  mem_msg_type_t                bank_type   [NP];
  logic [`MEM_OPAQUE_NBITS-1:0] bank_opaque [NP];
  logic [`MEM_LEN_NBITS-1:0]    bank_len    [NP];
  logic [MD-1:0]                bank_data   [NP];

  // response path
  net_resp_ctrl_t resp_ctrl     [NP];
  logic [MD-1:0]  resp_net_data [NP];
  logic [NS-1:0]  resp_dest     [NP];
  net_resp_msg_t  resp_in_msg   [NP];
  net_resp_msg_t  resp_out_msg  [NP];

  for (genvar g = 0; g < NP; g++) begin : g_port
    // core side, g is the core index
    mem_req_to_net #(.p_net_src(g)) req_adapter_i (
      .mode(req_mode[g]), .mem_type(req_type[g]), .mem_opaque(req_opaque[g]),
      .mem_addr(req_addr[g]), .mem_len(req_len[g]), .mem_data(req_data[g]),
      .net_ctrl(req_ctrl[g]), .net_data(req_net_data[g])
    );
    assign req_dest[g]   = req_ctrl[g].dest;
    assign req_in_msg[g] = '{ctrl: req_ctrl[g], data: req_net_data[g]};

    // bank side, g is the bank index
    mem_bank bank_i (
      .clk(clk), .rst_n(rst_n), .req_val(req_out_val[g]),
      .req_type(req_out_msg[g].ctrl.msg_type), .req_opaque(req_out_msg[g].ctrl.opaque),
      .req_addr(req_out_msg[g].ctrl.addr), .req_len(req_out_msg[g].ctrl.len),
      .req_data(req_out_msg[g].data), .resp_val(bank_val[g]), .resp_type(bank_type[g]),
      .resp_opaque(bank_opaque[g]), .resp_len(bank_len[g]), .resp_data(bank_data[g])
    );
    mem_resp_to_net #(.p_net_src(g)) resp_adapter_i (
      .mem_type(bank_type[g]), .mem_opaque(bank_opaque[g]), .mem_len(bank_len[g]),
      .mem_data(bank_data[g]), .net_ctrl(resp_ctrl[g]), .net_data(resp_net_data[g])
    );
    assign resp_dest[g]   = resp_ctrl[g].dest;
    assign resp_in_msg[g] = '{ctrl: resp_ctrl[g], data: resp_net_data[g]};

    // back at core g
    assign resp_type[g]   = resp_out_msg[g].ctrl.msg_type;
    assign resp_opaque[g] = resp_out_msg[g].ctrl.opaque;
    assign resp_len[g]    = resp_out_msg[g].ctrl.len;
    assign resp_data[g]   = resp_out_msg[g].data;
  end

  net_switch #(.p_msg_t(net_req_msg_t)) req_switch_i (
    .clk(clk), .rst_n(rst_n), .in_val(req_val), .in_dest(req_dest),
    .in_msg(req_in_msg), .out_val(req_out_val), .out_msg(req_out_msg)
  );

  net_switch #(.p_msg_t(net_resp_msg_t)) resp_switch_i (
    .clk(clk), .rst_n(rst_n), .in_val(bank_val), .in_dest(resp_dest),
    .in_msg(resp_in_msg), .out_val(resp_val), .out_msg(resp_out_msg)
  );

endmodule

/* mem_net_checker.sv */
//========================================
// memory network response checker
// matches responses to expected entries by opaque
//========================================

`include "mem_net_defines.svh"

module mem_net_checker
  import mem_net_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         resp_val    [`NET_NUM_PORTS],
  input  mem_msg_type_t                resp_type   [`NET_NUM_PORTS],
  input  logic [`MEM_OPAQUE_NBITS-1:0] resp_opaque [`NET_NUM_PORTS],
  input  logic [`MEM_LEN_NBITS-1:0]    resp_len    [`NET_NUM_PORTS],
  input  logic [`MEM_DATA_NBITS-1:0]   resp_data   [`NET_NUM_PORTS],
  input  logic                         exp_val     [`NET_NUM_PORTS],
  input  logic [`MEM_OPAQUE_NBITS-1:0] exp_opaque  [`NET_NUM_PORTS],
  input  mem_msg_type_t                exp_type    [`NET_NUM_PORTS],
  input  logic [`MEM_LEN_NBITS-1:0]    exp_len     [`NET_NUM_PORTS],
  input  logic [`MEM_DATA_NBITS-1:0]   exp_data    [`NET_NUM_PORTS],
  output int                           outstanding,
  output int                           mismatch_cnt,
  output int                           unexpected_cnt
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP = `NET_NUM_PORTS;
  localparam int KW = `MEM_OPAQUE_NBITS - `NET_SRCDEST_NBITS;
  localparam int NK = 2 ** KW;

  // expected entries per core, keyed by the opaque bits below the core id
  bit                           pend     [NP][NK];
  logic [`MEM_OPAQUE_NBITS-1:0] e_opaque [NP][NK];
  mem_msg_type_t                e_type   [NP][NK];
  logic [`MEM_LEN_NBITS-1:0]    e_len    [NP][NK];
  logic [`MEM_DATA_NBITS-1:0]   e_data   [NP][NK];

  task automatic compare_field(input int core, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] core %0d %s: got %h expected %h", core, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  always @(posedge clk) begin
    logic [KW-1:0] key;
    if (!rst_n) begin
      outstanding    = 0;
      mismatch_cnt   = 0;
      unexpected_cnt = 0;
      for (int c = 0; c < NP; c++) begin
        for (int k = 0; k < NK; k++) pend[c][k] = 1'b0;
      end
    end else begin
      for (int c = 0; c < NP; c++) begin
        if (resp_val[c]) begin
          key = resp_opaque[c][KW-1:0];
          if (!pend[c][key]) begin
            $display("core %0d received a response with opaque %h that no request waits for",
                     c, resp_opaque[c]);
            unexpected_cnt++;
          end else begin
            pend[c][key] = 1'b0;
            outstanding--;
            // top opaque bits must name this core
            compare_field(c, "resp_opaque", 32'(resp_opaque[c]), 32'(e_opaque[c][key]));
            compare_field(c, "resp_type", 32'(resp_type[c]), 32'(e_type[c][key]));
            compare_field(c, "resp_len", 32'(resp_len[c]), 32'(e_len[c][key]));
            compare_field(c, "resp_data", resp_data[c], e_data[c][key]);
          end
        end
        // new request issued by core c this cycle
        if (exp_val[c]) begin
          key               = exp_opaque[c][KW-1:0];
          pend[c][key]      = 1'b1;
          e_opaque[c][key]  = exp_opaque[c];
          e_type[c][key]    = exp_type[c];
          e_len[c][key]     = exp_len[c];
          e_data[c][key]    = exp_data[c];
          outstanding++;
        end
      end
    end
  end

endmodule

/* mem_net_tb.sv */
//========================================
// memory network testbench
// two cores of LCG traffic against a reference memory model
//========================================

`include "mem_net_defines.svh"

module mem_net_tb
  import mem_net_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP             = `NET_NUM_PORTS;
  localparam int KW             = `MEM_OPAQUE_NBITS - `NET_SRCDEST_NBITS;
  localparam int NUM_ROUNDS     = 60;
  localparam int NUM_REQS       = NUM_ROUNDS * NP;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 20 + 100;
  localparam int DRAIN_CYCLES   = 100;

  // region bases on both sides of the instruction and data splits
  localparam logic [31:0] ADDR_BASES [8] = '{
    32'h0000_0000, 32'h0000_3c00, 32'h0000_4000, 32'h0000_8000,
    32'h0000_bc00, 32'h0000_c000, 32'h0001_0000, 32'h0000_3c00
  };

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic                         req_val     [NP];
  logic                         req_mode    [NP];
  mem_msg_type_t                req_type    [NP];
  logic [`MEM_OPAQUE_NBITS-1:0] req_opaque  [NP];
  logic [`MEM_ADDR_NBITS-1:0]   req_addr    [NP];
  logic [`MEM_LEN_NBITS-1:0]    req_len     [NP];
  logic [`MEM_DATA_NBITS-1:0]   req_data    [NP];
  logic                         resp_val    [NP];
  mem_msg_type_t                resp_type   [NP];
  logic [`MEM_OPAQUE_NBITS-1:0] resp_opaque [NP];
  logic [`MEM_LEN_NBITS-1:0]    resp_len    [NP];
  logic [`MEM_DATA_NBITS-1:0]   resp_data   [NP];

  // expected response handed to the checker at issue time
  logic                         exp_val    [NP];
  logic [`MEM_OPAQUE_NBITS-1:0] exp_opaque [NP];
  mem_msg_type_t                exp_type   [NP];
  logic [`MEM_LEN_NBITS-1:0]    exp_len    [NP];
  logic [`MEM_DATA_NBITS-1:0]   exp_data   [NP];

  int            outstanding;
  int            mismatch_cnt;
  int            unexpected_cnt;
  int            cycle_cnt = 0;
  logic [31:0]   lcg_state = 32'd64;
  logic [KW-1:0] seq [NP];

  // shadow copy of both banks
  logic [`MEM_DATA_NBITS-1:0] shadow_mem [NP][`BANK_NWORDS];
  bit                         shadow_vld [NP][`BANK_NWORDS];

  always #2 clk = ~clk;

  mem_net_top mem_net_top_i (
    .clk(clk), .rst_n(rst_n), .req_val(req_val), .req_mode(req_mode),
    .req_type(req_type), .req_opaque(req_opaque), .req_addr(req_addr),
    .req_len(req_len), .req_data(req_data), .resp_val(resp_val),
    .resp_type(resp_type), .resp_opaque(resp_opaque), .resp_len(resp_len),
    .resp_data(resp_data)
  );

  mem_net_checker mem_net_checker_i (
    .clk(clk), .rst_n(rst_n), .resp_val(resp_val), .resp_type(resp_type),
    .resp_opaque(resp_opaque), .resp_len(resp_len), .resp_data(resp_data),
    .exp_val(exp_val), .exp_opaque(exp_opaque), .exp_type(exp_type),
    .exp_len(exp_len), .exp_data(exp_data), .outstanding(outstanding),
    .mismatch_cnt(mismatch_cnt), .unexpected_cnt(unexpected_cnt)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // destination rule picks the bank, then the bank rule on the shadow copy
  function automatic logic [31:0] ref_access(input logic mode, input mem_msg_type_t t,
                                             input logic [31:0] addr, input logic [31:0] data);
    logic       bank;
    logic [7:0] word;
    bank = mode ? (addr >= `DATA_BANK_SPLIT) : (addr >= `INST_BANK_SPLIT);
    word = addr[2 +: 8];
    if (t == MEM_MSG_WRITE) begin
      shadow_mem[bank][word] = data;
      shadow_vld[bank][word] = 1'b1;
      return '0;
    end
    return shadow_vld[bank][word] ? shadow_mem[bank][word] : '0;
  endfunction

  task automatic issue_request(input int c, input int rnd);
    logic [31:0] r;
    logic        mode;
    logic        wr;
    logic [2:0]  idx;
    logic [31:0] base;
    logic [31:0] addr;
    r = lcg_next();
    if (rnd < 5) begin
      // word 1 of both banks, reached through both modes
      mode = (rnd == 3);
      wr   = (rnd < 2);
      base = (rnd == 0 || rnd == 2) ? 32'h0 : 32'h4000;
      idx  = 3'd1;
    end else begin
      mode = r[16];
      wr   = r[17];
      idx  = r[20:18];
      base = ADDR_BASES[r[23:21]];
    end
    // each core owns its own half of every bank
    addr          = base | {22'b0, c[0], 4'b0, idx, 2'b00};
    req_val[c]    = 1'b1;
    req_mode[c]   = mode;
    req_type[c]   = mem_msg_type_t'(wr);
    req_opaque[c] = {r[24], seq[c]};
    req_addr[c]   = addr;
    req_len[c]    = '0;
    req_data[c]   = lcg_next();
    exp_val[c]    = 1'b1;
    exp_opaque[c] = {c[0], seq[c]};
    exp_type[c]   = req_type[c];
    exp_len[c]    = '0;
    exp_data[c]   = ref_access(mode, req_type[c], addr, req_data[c]);
    seq[c]        = seq[c] + KW'(1);
  endtask

  initial begin
    rst_n = 1'b0;
    for (int c = 0; c < NP; c++) begin
      req_val[c]    = 1'b0;
      req_mode[c]   = 1'b0;
      req_type[c]   = MEM_MSG_READ;
      req_opaque[c] = '0;
      req_addr[c]   = '0;
      req_len[c]    = '0;
      req_data[c]   = '0;
      exp_val[c]    = 1'b0;
      exp_opaque[c] = '0;
      exp_type[c]   = MEM_MSG_READ;
      exp_len[c]    = '0;
      exp_data[c]   = '0;
      seq[c]        = '0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // quiet stretch, any response here is unexpected
    repeat (8) @(negedge clk);
    for (int rnd = 0; rnd < NUM_ROUNDS; rnd++) begin
      // both cores issue together, then rest a cycle
      for (int c = 0; c < NP; c++) issue_request(c, rnd);
      @(negedge clk);
      for (int c = 0; c < NP; c++) begin
        req_val[c] = 1'b0;
        exp_val[c] = 1'b0;
      end
      @(negedge clk);
    end
    // wait for the last responses
    for (int i = 0; i < DRAIN_CYCLES && outstanding != 0; i++) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
    if (outstanding != 0) begin
      $display("%0d requests never received a response", outstanding);
    end
    $display("errors: %0d mismatched fields, %0d unexpected responses, %0d missing responses",
             mismatch_cnt, unexpected_cnt, outstanding);
    if (mismatch_cnt == 0 && unexpected_cnt == 0 && outstanding == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses still missing",
               cycle_cnt, outstanding);
      $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+.
mem_net_pkg.sv
mem_req_to_net.sv
mem_resp_to_net.sv
net_switch.sv
mem_bank.sv
mem_net_top.sv
mem_net_checker.sv
mem_net_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the memory network testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Mdir obj_dir \
  --top-module mem_net_tb -f project.f

./obj_dir/Vmem_net_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without a failure report"
